// ==== source/ctrl_config.svh ====
`ifndef CTRL_CONFIG_SVH
`define CTRL_CONFIG_SVH

// instruction fields
`define OPCODE_W 6
`define FUNCT_W  6

// room for the whole state set
`define STATE_W  5

// addm is the longest instruction, counted from FETCH
`define MAX_INSTR_CYCLES 6

`endif

// ==== source/ctrl_pkg.sv ====
`default_nettype none

`include "ctrl_config.svh"

package ctrl_pkg;

    typedef enum logic [`STATE_W-1:0] {
        FETCH,
        BRANCH_END,             // branch target into alu_out
        DECODE,
        A_MEM_READ,             // addm operand a
        B_MEM_READ,             // addm operand b
        DIVM,
        ALU_OP_1,               // slt
        DESLOC_CALC,            // shifter runs
        WRITE_BACK_1,
        ALU_OP_2,
        WRITE_BACK_2,
        JUMP_REG,
        DIV_MUL_REG_WRITE
    } ctrl_state_e;

    typedef enum logic [2:0] {
        CLS_NONE,
        CLS_ARITH,
        CLS_SLT,
        CLS_SHIFT,
        CLS_JR,
        CLS_DIVMUL,
        CLS_ADDM
    } instr_class_e;

    // meaning depends on the class, so codes repeat across classes
    typedef logic [1:0] op_variant_e;
    localparam op_variant_e VAR_ADD  = 2'd0;
    localparam op_variant_e VAR_SUB  = 2'd1;
    localparam op_variant_e VAR_AND  = 2'd2;
    localparam op_variant_e VAR_SLL  = 2'd0;
    localparam op_variant_e VAR_SRA  = 2'd1;
    localparam op_variant_e VAR_DIV  = 2'd0;
    localparam op_variant_e VAR_MULT = 2'd1;

    typedef enum logic [2:0] {
        ALU_PASS = 3'b000,
        ALU_ADD  = 3'b001,
        ALU_SUB  = 3'b010,
        ALU_AND  = 3'b011
    } alu_op_e;

    typedef enum logic [2:0] {
        SH_NONE        = 3'b000,
        SH_LEFT        = 3'b010,
        SH_RIGHT_ARITH = 3'b100
    } sh_op_e;

    typedef struct packed {
        logic       pc_write;
        logic       mem_read;
        logic       ir_write;
        logic       reg_write;
        logic       ab_from_memory;     // a/b loaded from memory data
        logic       div_mul_wr;
        logic       div_mul_to_reg;     // 1 picks mult
        logic [1:0] i_or_d;             // address mux
        logic [2:0] mem_to_reg;         // write-back mux
        logic [1:0] pc_src;
        alu_op_e    alu_op;
        logic [1:0] alu_src_a;
        logic [1:0] alu_src_b;
        logic [1:0] reg_dst;
        sh_op_e     sh_op;
    } ctrl_word_t;

endpackage

`default_nettype wire

// ==== source/instr_decoder.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module instr_decoder (
    input  wire [`OPCODE_W-1:0]     i_opcode,
    input  wire [`FUNCT_W-1:0]      i_funct,
    output ctrl_pkg::instr_class_e  o_class,
    output ctrl_pkg::op_variant_e   o_variant
);
    import ctrl_pkg::*;

    localparam logic [`OPCODE_W-1:0] OP_RTYPE = 6'b000000;

    localparam logic [`FUNCT_W-1:0] FN_SLL  = 6'b000000;
    localparam logic [`FUNCT_W-1:0] FN_SRA  = 6'b000011;
    localparam logic [`FUNCT_W-1:0] FN_ADDM = 6'b000101;
    localparam logic [`FUNCT_W-1:0] FN_JR   = 6'b001000;
    localparam logic [`FUNCT_W-1:0] FN_MULT = 6'b011000;
    localparam logic [`FUNCT_W-1:0] FN_DIV  = 6'b011010;
    localparam logic [`FUNCT_W-1:0] FN_ADD  = 6'b100000;
    localparam logic [`FUNCT_W-1:0] FN_SUB  = 6'b100010;
    localparam logic [`FUNCT_W-1:0] FN_AND  = 6'b100100;
    localparam logic [`FUNCT_W-1:0] FN_SLT  = 6'b101010;

    always_comb begin
        o_class   = CLS_NONE;
        o_variant = VAR_ADD;                        // zero unless the class uses it
        case ({i_opcode, i_funct})
            {OP_RTYPE, FN_ADD}: begin
                o_class   = CLS_ARITH;
                o_variant = VAR_ADD;
            end
            {OP_RTYPE, FN_SUB}: begin
                o_class   = CLS_ARITH;
                o_variant = VAR_SUB;
            end
            {OP_RTYPE, FN_AND}: begin
                o_class   = CLS_ARITH;
                o_variant = VAR_AND;
            end
            {OP_RTYPE, FN_SLL}: begin
                o_class   = CLS_SHIFT;
                o_variant = VAR_SLL;
            end
            {OP_RTYPE, FN_SRA}: begin
                o_class   = CLS_SHIFT;
                o_variant = VAR_SRA;
            end
            {OP_RTYPE, FN_MULT}: begin
                o_class   = CLS_DIVMUL;
                o_variant = VAR_MULT;
            end
            {OP_RTYPE, FN_DIV}: begin
                o_class   = CLS_DIVMUL;
                o_variant = VAR_DIV;
            end
            {OP_RTYPE, FN_SLT}:  o_class = CLS_SLT;
            {OP_RTYPE, FN_JR}:   o_class = CLS_JR;
            {OP_RTYPE, FN_ADDM}: o_class = CLS_ADDM;
            default:             o_class = CLS_NONE;    // straight back to fetch
        endcase
    end

endmodule

`default_nettype wire

// ==== source/state_sequencer.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module state_sequencer (
    input  wire                          clk,
    input  wire                          reset,
    input  wire ctrl_pkg::instr_class_e  i_class,
    input  wire ctrl_pkg::op_variant_e   i_variant,
    output ctrl_pkg::ctrl_state_e        o_state,
    output ctrl_pkg::op_variant_e        o_variant
);
    import ctrl_pkg::*;

    localparam int AGE_W = $clog2(`MAX_INSTR_CYCLES + 1);
    localparam logic [AGE_W-1:0] AGE_LIMIT = AGE_W'(`MAX_INSTR_CYCLES);

    ctrl_state_e        state_q;
    ctrl_state_e        state_d;
    op_variant_e        variant_q;
    logic [AGE_W-1:0]   fetch_age;                  // cycles since FETCH was entered

    always_comb begin
        state_d = FETCH;
        case (state_q)
            FETCH:       state_d = BRANCH_END;
            BRANCH_END:  state_d = DECODE;
            DECODE: begin
                case (i_class)
                    CLS_ARITH:  state_d = ALU_OP_2;
                    CLS_SLT:    state_d = ALU_OP_1;
                    CLS_SHIFT:  state_d = DESLOC_CALC;
                    CLS_JR:     state_d = JUMP_REG;
                    CLS_DIVMUL: state_d = DIV_MUL_REG_WRITE;
                    CLS_ADDM:   state_d = A_MEM_READ;
                    default:    state_d = FETCH;
                endcase
            end
            A_MEM_READ:  state_d = B_MEM_READ;
            B_MEM_READ:  state_d = DIVM;
            DESLOC_CALC: state_d = WRITE_BACK_1;
            ALU_OP_2:    state_d = WRITE_BACK_2;
            default:     state_d = FETCH;           // last execution states
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state_q <= FETCH;
        end else begin
            state_q <= state_d;
        end
    end

    // held through execution
    always_ff @(posedge clk) begin
        if (state_q == DECODE) begin
            variant_q <= i_variant;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            fetch_age <= '0;
        end else if (state_q == FETCH) begin
            fetch_age <= AGE_W'(1);
        end else begin
            fetch_age <= fetch_age + AGE_W'(1);
        end
    end

    assign o_state   = state_q;
    assign o_variant = variant_q;

    a_state_legal: assert property (@(posedge clk) disable iff (reset)
        state_q inside {FETCH, BRANCH_END, DECODE, A_MEM_READ, B_MEM_READ, DIVM,
                        ALU_OP_1, DESLOC_CALC, WRITE_BACK_1, ALU_OP_2, WRITE_BACK_2,
                        JUMP_REG, DIV_MUL_REG_WRITE})
        else $error("state register holds an undefined encoding");

    a_fetch_recurs: assert property (@(posedge clk) disable iff (reset)
        (state_q != FETCH) |-> (fetch_age < AGE_LIMIT))
        else $error("no return to FETCH within the longest instruction");

endmodule

`default_nettype wire

// ==== source/control_word_gen.sv ====
`timescale 1ns/100ps
`default_nettype none

module control_word_gen (
    input  wire                         clk,
    input  wire                         reset,
    input  wire ctrl_pkg::ctrl_state_e  i_state,
    input  wire ctrl_pkg::op_variant_e  i_variant,
    output ctrl_pkg::ctrl_word_t        o_ctrl
);
    import ctrl_pkg::*;

    ctrl_word_t word_d;

    always_comb begin
        word_d = '0;
        case (i_state)
            FETCH: begin
                word_d.pc_write  = 1'b1;            // pc + 4
                word_d.mem_read  = 1'b1;
                word_d.ir_write  = 1'b1;
                word_d.alu_op    = ALU_ADD;
                word_d.alu_src_b = 2'b01;
            end
            BRANCH_END: begin
                word_d.alu_op    = ALU_ADD;
                word_d.alu_src_b = 2'b11;           // shifted offset
            end
            A_MEM_READ: begin
                word_d.mem_read = 1'b1;
                word_d.i_or_d   = 2'b01;
            end
            B_MEM_READ: begin
                word_d.mem_read = 1'b1;
                word_d.i_or_d   = 2'b10;
            end
            DIVM: begin
                word_d.div_mul_wr = 1'b1;
                word_d.alu_op     = ALU_SUB;
            end
            ALU_OP_1: begin
                word_d.reg_write  = 1'b1;
                word_d.alu_op     = ALU_SUB;        // compare by subtract
                word_d.mem_to_reg = 3'b011;
                word_d.alu_src_a  = 2'b01;
                word_d.reg_dst    = 2'b01;
            end
            DESLOC_CALC: begin
                word_d.sh_op = (i_variant == VAR_SLL) ? SH_LEFT : SH_RIGHT_ARITH;
            end
            WRITE_BACK_1: begin
                word_d.reg_write  = 1'b1;
                word_d.mem_to_reg = 3'b100;         // shifter result
                word_d.reg_dst    = 2'b01;
            end
            ALU_OP_2: begin
                case (i_variant)
                    VAR_SUB: word_d.alu_op = ALU_SUB;
                    VAR_AND: word_d.alu_op = ALU_AND;
                    default: word_d.alu_op = ALU_ADD;
                endcase
                word_d.alu_src_a = 2'b01;
            end
            WRITE_BACK_2: begin
                word_d.reg_write  = 1'b1;
                word_d.mem_to_reg = 3'b101;
                word_d.reg_dst    = 2'b01;
            end
            JUMP_REG: begin
                word_d.pc_write = 1'b1;
                word_d.pc_src   = 2'b11;            // rs into pc
            end
            DIV_MUL_REG_WRITE: begin
                word_d.ab_from_memory = 1'b1;
                word_d.div_mul_wr     = 1'b1;
                word_d.div_mul_to_reg = (i_variant == VAR_MULT);
            end
            default: word_d = '0;                   // DECODE drives nothing
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            o_ctrl <= '0;
        end else begin
            o_ctrl <= word_d;
        end
    end

    a_fetch_reads_mem: assert property (@(posedge clk) disable iff (reset)
        o_ctrl.ir_write |-> o_ctrl.mem_read)
        else $error("ir_write without mem_read");

    a_single_writer: assert property (@(posedge clk) disable iff (reset)
        !(o_ctrl.reg_write && o_ctrl.pc_write))
        else $error("reg_write and pc_write asserted together");

endmodule

`default_nettype wire

// ==== source/control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module control_unit (
    input  wire                    clk,
    input  wire                    reset,
    input  wire [`OPCODE_W-1:0]    i_opcode,
    input  wire [`FUNCT_W-1:0]     i_funct,
    output ctrl_pkg::ctrl_word_t   o_ctrl
);
    import ctrl_pkg::*;

    instr_class_e   dec_class;
    op_variant_e    dec_variant;
    op_variant_e    held_variant;                   // latched at DECODE
    ctrl_state_e    state;

    instr_decoder u_decoder (
        .i_opcode  (i_opcode),
        .i_funct   (i_funct),
        .o_class   (dec_class),
        .o_variant (dec_variant)
    );

    state_sequencer u_sequencer (
        .clk       (clk),
        .reset     (reset),
        .i_class   (dec_class),
        .i_variant (dec_variant),
        .o_state   (state),
        .o_variant (held_variant)
    );

    control_word_gen u_word_gen (
        .clk       (clk),
        .reset     (reset),
        .i_state   (state),
        .i_variant (held_variant),
        .o_ctrl    (o_ctrl)
    );

endmodule

`default_nettype wire

// ==== verification/tb_checker.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module tb_checker (
    input  wire                        clk,
    input  wire                        reset,
    input  wire [`OPCODE_W-1:0]        i_opcode,
    input  wire [`FUNCT_W-1:0]         i_funct,
    input  wire                        i_row_start,
    input  wire ctrl_pkg::ctrl_word_t  i_ctrl,
    output int                         o_checks,
    output int                         o_errors
);
    import ctrl_pkg::*;

    ctrl_state_e  exp_state;
    op_variant_e  exp_variant;
    ctrl_word_t   exp_ctrl;                         // model of the registered output
    logic         model_live = 1'b0;
    logic         row_due;

    function automatic instr_class_e decode_class(input logic [`OPCODE_W-1:0] op,
                                                  input logic [`FUNCT_W-1:0] fn);
        if (op != '0) begin
            return CLS_NONE;                        // only R-type is kept
        end
        case (fn)
            6'b100000, 6'b100010, 6'b100100: return CLS_ARITH;
            6'b101010:                       return CLS_SLT;
            6'b000000, 6'b000011:            return CLS_SHIFT;
            6'b001000:                       return CLS_JR;
            6'b011000, 6'b011010:            return CLS_DIVMUL;
            6'b000101:                       return CLS_ADDM;
            default:                         return CLS_NONE;
        endcase
    endfunction

    function automatic op_variant_e decode_variant(input logic [`FUNCT_W-1:0] fn);
        case (fn)
            6'b100010: return VAR_SUB;
            6'b100100: return VAR_AND;
            6'b000011: return VAR_SRA;
            6'b011000: return VAR_MULT;
            default:   return 2'd0;                 // add, sll, div
        endcase
    endfunction

    function automatic ctrl_state_e next_state(input ctrl_state_e s, input instr_class_e cls);
        case (s)
            FETCH:       return BRANCH_END;
            BRANCH_END:  return DECODE;
            DECODE: begin
                case (cls)
                    CLS_ARITH:  return ALU_OP_2;
                    CLS_SLT:    return ALU_OP_1;
                    CLS_SHIFT:  return DESLOC_CALC;
                    CLS_JR:     return JUMP_REG;
                    CLS_DIVMUL: return DIV_MUL_REG_WRITE;
                    CLS_ADDM:   return A_MEM_READ;
                    default:    return FETCH;
                endcase
            end
            A_MEM_READ:  return B_MEM_READ;
            B_MEM_READ:  return DIVM;
            DESLOC_CALC: return WRITE_BACK_1;
            ALU_OP_2:    return WRITE_BACK_2;
            default:     return FETCH;
        endcase
    endfunction

    function automatic ctrl_word_t expected_word(input ctrl_state_e s, input op_variant_e v);
        ctrl_word_t w;
        w = '0;
        case (s)
            FETCH: begin
                w.pc_write  = 1'b1;
                w.mem_read  = 1'b1;
                w.ir_write  = 1'b1;
                w.alu_op    = ALU_ADD;
                w.alu_src_b = 2'b01;
            end
            BRANCH_END: begin
                w.alu_op    = ALU_ADD;
                w.alu_src_b = 2'b11;
            end
            A_MEM_READ: begin
                w.mem_read = 1'b1;
                w.i_or_d   = 2'b01;
            end
            B_MEM_READ: begin
                w.mem_read = 1'b1;
                w.i_or_d   = 2'b10;
            end
            DIVM: begin
                w.div_mul_wr = 1'b1;
                w.alu_op     = ALU_SUB;
            end
            ALU_OP_1: begin
                w.reg_write  = 1'b1;
                w.alu_op     = ALU_SUB;
                w.mem_to_reg = 3'b011;
                w.alu_src_a  = 2'b01;
                w.reg_dst    = 2'b01;
            end
            DESLOC_CALC: begin
                if (v == VAR_SRA) begin
                    w.sh_op = SH_RIGHT_ARITH;
                end else begin
                    w.sh_op = SH_LEFT;
                end
            end
            WRITE_BACK_1: begin
                w.reg_write  = 1'b1;
                w.mem_to_reg = 3'b100;
                w.reg_dst    = 2'b01;
            end
            ALU_OP_2: begin
                case (v)
                    VAR_ADD: w.alu_op = ALU_ADD;
                    VAR_SUB: w.alu_op = ALU_SUB;
                    VAR_AND: w.alu_op = ALU_AND;
                    default: w.alu_op = ALU_PASS;
                endcase
                w.alu_src_a = 2'b01;
            end
            WRITE_BACK_2: begin
                w.reg_write  = 1'b1;
                w.mem_to_reg = 3'b101;
                w.reg_dst    = 2'b01;
            end
            JUMP_REG: begin
                w.pc_write = 1'b1;
                w.pc_src   = 2'b11;
            end
            DIV_MUL_REG_WRITE: begin
                w.ab_from_memory = 1'b1;
                w.div_mul_wr     = 1'b1;
                w.div_mul_to_reg = (v == VAR_MULT);
            end
            default: w = '0;                        // DECODE
        endcase
        return w;
    endfunction

    task automatic compare_field(input string name, input logic [31:0] exp_v,
                                 input logic [31:0] act_v);
        if (exp_v !== act_v) begin
            o_errors++;
            $display("[FAIL] o_ctrl.%s expected %0h got %0h at %0t", name, exp_v, act_v,
                     $time);
        end
    endtask

    task automatic compare_word(input ctrl_word_t e, input ctrl_word_t a);
        o_checks++;
        compare_field("pc_write", 32'(e.pc_write), 32'(a.pc_write));
        compare_field("mem_read", 32'(e.mem_read), 32'(a.mem_read));
        compare_field("ir_write", 32'(e.ir_write), 32'(a.ir_write));
        compare_field("reg_write", 32'(e.reg_write), 32'(a.reg_write));
        compare_field("ab_from_memory", 32'(e.ab_from_memory), 32'(a.ab_from_memory));
        compare_field("div_mul_wr", 32'(e.div_mul_wr), 32'(a.div_mul_wr));
        compare_field("div_mul_to_reg", 32'(e.div_mul_to_reg), 32'(a.div_mul_to_reg));
        compare_field("i_or_d", 32'(e.i_or_d), 32'(a.i_or_d));
        compare_field("mem_to_reg", 32'(e.mem_to_reg), 32'(a.mem_to_reg));
        compare_field("pc_src", 32'(e.pc_src), 32'(a.pc_src));
        compare_field("alu_op", 32'(e.alu_op), 32'(a.alu_op));
        compare_field("alu_src_a", 32'(e.alu_src_a), 32'(a.alu_src_a));
        compare_field("alu_src_b", 32'(e.alu_src_b), 32'(a.alu_src_b));
        compare_field("reg_dst", 32'(e.reg_dst), 32'(a.reg_dst));
        compare_field("sh_op", 32'(e.sh_op), 32'(a.sh_op));
    endtask

    initial begin
        o_checks = 0;
        o_errors = 0;
    end

    // reference walk with the output one cycle behind the state
    always @(posedge clk) begin
        model_live <= 1'b1;
        row_due    <= i_row_start;
        if (reset) begin
            exp_state <= FETCH;
            exp_ctrl  <= '0;
        end else begin
            exp_ctrl  <= expected_word(exp_state, exp_variant);
            exp_state <= next_state(exp_state, decode_class(i_opcode, i_funct));
        end
        if (exp_state == DECODE) begin
            exp_variant <= decode_variant(i_funct);
        end
    end

    always @(negedge clk) begin
        if (model_live) begin
            compare_word(exp_ctrl, i_ctrl);
            if (row_due && i_ctrl !== expected_word(FETCH, VAR_ADD)) begin
                o_errors++;                         // row length off
                $display("[FAIL] o_ctrl at row start expected %0h got %0h at %0t",
                         expected_word(FETCH, VAR_ADD), i_ctrl, $time);
            end
        end
    end

endmodule

`default_nettype wire

// ==== verification/tb_control_unit.sv ====
`timescale 1ns/100ps
`default_nettype none

`include "ctrl_config.svh"

module tb_control_unit;
    import ctrl_pkg::*;

    localparam int NUM_ROWS     = 19;
    localparam int RESET_CYCLES = 16;
    localparam int SPARE_CYCLES = 32;

    typedef struct packed {
        logic [`OPCODE_W-1:0] opcode;
        logic [`FUNCT_W-1:0]  funct;
        logic [3:0]           cycles;               // FETCH through last execution state
        logic                 toggle;               // noise on the inputs outside DECODE
    } row_t;

    logic                  clk;
    logic                  reset;
    logic [`OPCODE_W-1:0]  opcode;
    logic [`FUNCT_W-1:0]   funct;
    logic                  row_start;
    ctrl_word_t            ctrl;
    int                    check_count;
    int                    error_count;
    int                    cycle_count = 0;
    int                    timeout_limit;
    integer                seed;
    row_t                  rows [NUM_ROWS];

    control_unit dut (
        .clk      (clk),
        .reset    (reset),
        .i_opcode (opcode),
        .i_funct  (funct),
        .o_ctrl   (ctrl)
    );

    tb_checker u_checker (
        .clk         (clk),
        .reset       (reset),
        .i_opcode    (opcode),
        .i_funct     (funct),
        .i_row_start (row_start),
        .i_ctrl      (ctrl),
        .o_checks    (check_count),
        .o_errors    (error_count)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= timeout_limit) begin
            $display("timeout: run did not finish within %0d cycles", timeout_limit);
            $display("TEST FAIL");
            $finish;
        end
    end

    task automatic fill_rows();
        rows[0]  = '{6'b000000, 6'b100000, 4'd5, 1'b0};    // add
        rows[1]  = '{6'b000000, 6'b100010, 4'd5, 1'b0};    // sub
        rows[2]  = '{6'b000000, 6'b100100, 4'd5, 1'b0};    // and
        rows[3]  = '{6'b000000, 6'b101010, 4'd4, 1'b0};    // slt
        rows[4]  = '{6'b000000, 6'b000000, 4'd5, 1'b0};    // sll
        rows[5]  = '{6'b000000, 6'b000011, 4'd5, 1'b0};    // sra
        rows[6]  = '{6'b000000, 6'b001000, 4'd4, 1'b0};    // jr
        rows[7]  = '{6'b000000, 6'b011000, 4'd4, 1'b0};    // mult
        rows[8]  = '{6'b000000, 6'b011010, 4'd4, 1'b0};    // div
        rows[9]  = '{6'b000000, 6'b000101, 4'd6, 1'b0};    // addm
        rows[10] = '{6'b000000, 6'b111111, 4'd3, 1'b0};    // unknown funct
        rows[11] = '{6'b100011, 6'b000000, 4'd3, 1'b0};    // lw
        rows[12] = '{6'b000010, 6'b100000, 4'd3, 1'b0};    // j
        rows[13] = '{6'b000100, 6'b100010, 4'd3, 1'b0};    // beq
        rows[14] = '{6'b000000, 6'b100000, 4'd5, 1'b1};
        rows[15] = '{6'b000000, 6'b000011, 4'd5, 1'b1};
        rows[16] = '{6'b000000, 6'b011000, 4'd4, 1'b1};
        rows[17] = '{6'b000000, 6'b000101, 4'd6, 1'b1};
        rows[18] = '{6'b000000, 6'b100010, 4'd5, 1'b1};
    endtask

    // called 1 ns after the edge that enters FETCH
    task automatic run_row(input row_t r);
        logic [11:0] noise;
        int          c;
        for (c = 0; c < int'(r.cycles); c++) begin
            if (r.toggle && c != 2) begin           // cycle 2 is DECODE
                noise  = 12'($random(seed));
                opcode = noise[11:6];
                funct  = noise[5:0];
            end else begin
                opcode = r.opcode;
                funct  = r.funct;
            end
            row_start = (c == 0);
            @(posedge clk);
            #1;
        end
    endtask

    initial begin
        int i;
        seed      = 32'h3f81;
        clk       = 1'b0;
        reset     = 1'b1;
        opcode    = '0;
        funct     = '0;
        row_start = 1'b0;
        fill_rows();
        timeout_limit = RESET_CYCLES + SPARE_CYCLES;
        for (i = 0; i < NUM_ROWS; i++) begin
            timeout_limit += int'(rows[i].cycles);
        end

        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        reset = 1'b0;
        for (i = 0; i < NUM_ROWS; i++) begin
            run_row(rows[i]);
        end

        row_start = 1'b1;                           // closes the last row
        @(posedge clk);
        #1;
        row_start = 1'b0;
        @(posedge clk);
        @(negedge clk);
        #1;

        $display("checked %0d words, %0d errors", check_count, error_count);
        if (error_count == 0 && check_count > 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== src.f ====
+incdir+source
source/ctrl_pkg.sv
source/instr_decoder.sv
source/state_sequencer.sv
source/control_word_gen.sv
source/control_unit.sv
verification/tb_checker.sv
verification/tb_control_unit.sv

// ==== Makefile ====
TOP := tb_control_unit

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -f src.f --top-module $(TOP)

sim:
	verilator --binary --assert -Wno-fatal -f src.f --top-module $(TOP) -Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "TEST PASS"

clean:
	rm -rf obj_dir
